//--- hdl/eth_dma_pkg.sv
package eth_dma_pkg;

   // axi4 bus widths
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int AXI_ID_W   = 1;
   localparam int AXI_LEN_W  = 8;

   // fixed read address fields
   localparam logic [2:0] AXI_SIZE_4B    = 3'd2;     // 4 bytes per beat
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;
   localparam logic [3:0] AXI_CACHE_RD   = 4'h2;     // normal non-cacheable
   localparam logic [2:0] AXI_PROT_RD    = 3'b010;   // non-secure data access

   // frame buffer and request limits
   localparam int BUF_ADDR_W = 9;                    // 512 words
   localparam int DMA_LEN_W  = 10;
   localparam logic [DMA_LEN_W-1:0]  DMA_LEN_MAX = 10'd1020;
   localparam logic [BUF_ADDR_W-1:0] DMA_R_START = '0;

   typedef struct packed {
      logic [AXI_ID_W-1:0]   id;
      logic [AXI_ADDR_W-1:0] addr;
      logic [AXI_LEN_W-1:0]  len;     // beats minus one
      logic [2:0]            size;
      logic [1:0]            burst;
      logic                  lock;
      logic [3:0]            cache;
      logic [2:0]            prot;
      logic [3:0]            qos;
   } axi_ar_t;

   typedef struct packed {
      logic [AXI_ID_W-1:0]   id;
      logic [AXI_DATA_W-1:0] data;
      logic [1:0]            resp;    // not checked here
      logic                  last;
   } axi_r_t;

   typedef struct packed {
      logic                  en;
      logic [BUF_ADDR_W-1:0] addr;
      logic [AXI_DATA_W-1:0] data;
   } buf_wr_t;

   typedef enum logic [2:0] {IDLE, ADDR, DATA, FLUSH, DONE} dma_state_e;

endpackage

//--- hdl/eth_burst_align.sv
module eth_burst_align (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic [1:0]                         offset,     // dma_addr[1:0]
   input  logic [eth_dma_pkg::DMA_LEN_W-1:0]  len,
   input  logic                               start,      // request accepted
   input  eth_dma_pkg::axi_r_t                beat,
   input  logic                               beat_en,
   input  logic                               flush,
   output logic [eth_dma_pkg::AXI_LEN_W-1:0]  len_beats,
   output logic [eth_dma_pkg::AXI_DATA_W-1:0] word,
   output logic                               word_en
);

   logic [eth_dma_pkg::DMA_LEN_W:0]     span;        // offset + len + 3
   logic [eth_dma_pkg::DMA_LEN_W:0]     len_up;      // len + 3
   logic [eth_dma_pkg::DMA_LEN_W-2:0]   n_beats;
   logic [eth_dma_pkg::DMA_LEN_W-2:0]   beats_m1;
   logic [eth_dma_pkg::DMA_LEN_W-2:0]   n_words;
   logic [eth_dma_pkg::DMA_LEN_W-2:0]   words_left;  // words still owed
   logic [1:0]                          off_q;
   logic [1:0]                          tail_q;      // bytes in last word, 0 means 4
   logic                                first;       // no beat seen yet
   logic [eth_dma_pkg::AXI_DATA_W-1:0]  prev;        // previous beat data
   logic [eth_dma_pkg::AXI_DATA_W-1:0]  cur;
   logic [2*eth_dma_pkg::AXI_DATA_W-1:0] pair;
   logic [eth_dma_pkg::AXI_DATA_W-1:0]  raw;
   logic [eth_dma_pkg::AXI_DATA_W-1:0]  mask;

   // burst length covers offset plus len bytes, rounded up to words
   assign span      = {1'b0, len} + (eth_dma_pkg::DMA_LEN_W+1)'(offset)
                      + (eth_dma_pkg::DMA_LEN_W+1)'(3);
   assign n_beats   = span[eth_dma_pkg::DMA_LEN_W:2];
   assign beats_m1  = n_beats - 1'b1;
   assign len_beats = beats_m1[eth_dma_pkg::AXI_LEN_W-1:0];

   assign len_up  = {1'b0, len} + (eth_dma_pkg::DMA_LEN_W+1)'(3);
   assign n_words = len_up[eth_dma_pkg::DMA_LEN_W:2];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         off_q      <= '0;
         tail_q     <= '0;
         words_left <= '0;
         first      <= 1'b0;
      end else if (start) begin
         off_q      <= offset;
         tail_q     <= len[1:0];
         words_left <= n_words;
         first      <= 1'b1;
      end else begin
         if (beat_en) first <= 1'b0;
         if (word_en) words_left <= words_left - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (beat_en) prev <= beat.data;
   end

   // upper bytes of prev beat, then lower bytes of current beat
   assign cur  = flush ? '0 : beat.data;   // nothing left to read in flush
   assign pair = {cur, prev} >> {off_q, 3'b000};
   assign raw  = (off_q == 2'd0) ? beat.data : pair[eth_dma_pkg::AXI_DATA_W-1:0];

   always_comb begin
      mask = '1;
      if (words_left == 1) begin   // last word of the frame
         case (tail_q)
            2'd1:    mask = 32'h0000_00ff;
            2'd2:    mask = 32'h0000_ffff;
            2'd3:    mask = 32'h00ff_ffff;
            default: mask = '1;
         endcase
      end
   end

   assign word    = raw & mask;
   // unaligned first beat only primes prev
   assign word_en = (beat_en && (off_q == 2'd0 || !first)) || (flush && words_left != '0);

   a_no_extra_word: assert property (@(posedge clk) disable iff (!arst_n)
      word_en |-> words_left != '0)
      else $error("aligned word issued with no words owed");

   a_flush_drains: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> words_left == '0)
      else $error("words still owed after flush");

endmodule

//--- hdl/eth_dma_rd.sv
module eth_dma_rd (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic [eth_dma_pkg::AXI_ADDR_W-1:0]  dma_addr,
   input  logic [eth_dma_pkg::DMA_LEN_W-1:0]   dma_len,
   input  logic                                dma_run,
   output logic                                dma_ready,
   output eth_dma_pkg::axi_ar_t                ar,
   output logic                                arvalid,
   input  logic                                arready,
   input  eth_dma_pkg::axi_r_t                 r,
   input  logic                                rvalid,
   output logic                                rready,
   output eth_dma_pkg::buf_wr_t                buf_wr
);

   eth_dma_pkg::dma_state_e               state;
   logic [eth_dma_pkg::AXI_ADDR_W-1:0]    ar_addr;
   logic [eth_dma_pkg::AXI_LEN_W-1:0]     ar_len;
   logic [eth_dma_pkg::AXI_LEN_W-1:0]     len_beats;
   logic [eth_dma_pkg::AXI_DATA_W-1:0]    word;
   logic                                  word_en;
   logic                                  start;
   logic                                  beat_en;
   logic                                  flush;
   logic [eth_dma_pkg::BUF_ADDR_W-1:0]    waddr;     // next buffer word
   logic                                  wr_en;
   logic [eth_dma_pkg::BUF_ADDR_W-1:0]    wr_addr;
   logic [eth_dma_pkg::AXI_DATA_W-1:0]    wr_data;

   assign start   = (state == eth_dma_pkg::IDLE) && dma_run;   // run ignored when busy
   assign beat_en = rvalid && rready;
   assign flush   = (state == eth_dma_pkg::FLUSH);

   eth_burst_align u_align (
      .clk       (clk),
      .arst_n    (arst_n),
      .offset    (dma_addr[1:0]),
      .len       (dma_len),
      .start     (start),
      .beat      (r),
      .beat_en   (beat_en),
      .flush     (flush),
      .len_beats (len_beats),
      .word      (word),
      .word_en   (word_en)
   );

   assign ar = '{
      id:    '0,
      addr:  ar_addr,
      len:   ar_len,
      size:  eth_dma_pkg::AXI_SIZE_4B,
      burst: eth_dma_pkg::AXI_BURST_INCR,
      lock:  1'b0,
      cache: eth_dma_pkg::AXI_CACHE_RD,
      prot:  eth_dma_pkg::AXI_PROT_RD,
      qos:   '0
   };

   // request latch, word aligned start address
   always_ff @(posedge clk) begin
      if (start) begin
         ar_addr <= {dma_addr[eth_dma_pkg::AXI_ADDR_W-1:2], 2'b00};
         ar_len  <= len_beats;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= eth_dma_pkg::IDLE;
         arvalid   <= 1'b0;
         rready    <= 1'b0;
         dma_ready <= 1'b1;
      end else begin
         case (state)
            eth_dma_pkg::IDLE: if (dma_run) begin
               dma_ready <= 1'b0;
               arvalid   <= 1'b1;
               state     <= eth_dma_pkg::ADDR;
            end
            eth_dma_pkg::ADDR: if (arready) begin   // hold ar until accepted
               arvalid <= 1'b0;
               rready  <= 1'b1;
               state   <= eth_dma_pkg::DATA;
            end
            eth_dma_pkg::DATA: if (beat_en && r.last) begin
               rready <= 1'b0;
               state  <= eth_dma_pkg::FLUSH;
            end
            eth_dma_pkg::FLUSH: state <= eth_dma_pkg::DONE;   // pending word out
            eth_dma_pkg::DONE: begin
               dma_ready <= 1'b1;
               state     <= eth_dma_pkg::IDLE;
            end
            default: state <= eth_dma_pkg::IDLE;
         endcase
      end
   end

   // one buffer write per aligned word, a cycle later
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_en <= 1'b0;
         waddr <= '0;
      end else begin
         wr_en <= word_en;
         if (start) waddr <= eth_dma_pkg::DMA_R_START;
         else if (word_en) waddr <= waddr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (word_en) begin
         wr_addr <= waddr;
         wr_data <= word;
      end
   end

   assign buf_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

   a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
      arvalid && !arready |=> arvalid && $stable(ar))
      else $error("ar changed before arready");

   a_run_len: assert property (@(posedge clk) disable iff (!arst_n)
      start |-> dma_len != '0 && dma_len <= eth_dma_pkg::DMA_LEN_MAX)
      else $error("dma_len out of range on run");

   a_last_in_data: assert property (@(posedge clk) disable iff (!arst_n)
      rvalid && r.last |-> state == eth_dma_pkg::DATA)
      else $error("last beat outside the data phase");

endmodule

//--- hdl/eth_frame_buf.sv
module eth_frame_buf (
   input  logic                                clk,
   input  eth_dma_pkg::buf_wr_t                buf_wr,
   input  logic [eth_dma_pkg::BUF_ADDR_W-1:0]  raddr,
   output logic [eth_dma_pkg::AXI_DATA_W-1:0]  rdata
);

   // 512 x 32, one write port, one read port
   logic [eth_dma_pkg::AXI_DATA_W-1:0] mem [0:(1 << eth_dma_pkg::BUF_ADDR_W)-1];

   always_ff @(posedge clk) begin
      if (buf_wr.en) mem[buf_wr.addr] <= buf_wr.data;   // dma side
   end

   // mac side read, data one cycle after raddr
   always_ff @(posedge clk) begin
      rdata <= mem[raddr];
   end

endmodule

//--- hdl/eth_dma_rd_top.sv
module eth_dma_rd_top (
   input  logic                                clk,
   input  logic                                arst_n,

   // axi4 read address channel
   output eth_dma_pkg::axi_ar_t                ar,
   output logic                                arvalid,
   input  logic                                arready,

   // axi4 read data channel
   input  eth_dma_pkg::axi_r_t                 r,
   input  logic                                rvalid,
   output logic                                rready,

   // configuration
   input  logic [eth_dma_pkg::AXI_ADDR_W-1:0]  dma_addr,
   input  logic [eth_dma_pkg::DMA_LEN_W-1:0]   dma_len,
   input  logic                                dma_run,
   output logic                                dma_ready,

   // mac side buffer read
   input  logic [eth_dma_pkg::BUF_ADDR_W-1:0]  buf_raddr,
   output logic [eth_dma_pkg::AXI_DATA_W-1:0]  buf_rdata
);

   eth_dma_pkg::buf_wr_t buf_wr;   // sequencer to buffer

   eth_dma_rd u_dma_rd (
      .clk       (clk),
      .arst_n    (arst_n),
      .dma_addr  (dma_addr),
      .dma_len   (dma_len),
      .dma_run   (dma_run),
      .dma_ready (dma_ready),
      .ar        (ar),
      .arvalid   (arvalid),
      .arready   (arready),
      .r         (r),
      .rvalid    (rvalid),
      .rready    (rready),
      .buf_wr    (buf_wr)
   );

   eth_frame_buf u_frame_buf (
      .clk    (clk),
      .buf_wr (buf_wr),
      .raddr  (buf_raddr),
      .rdata  (buf_rdata)
   );

endmodule

//--- tb/axi_rd_mem_model.sv
module axi_rd_mem_model (
   input  logic                 clk,
   input  logic                 arst_n,
   input  eth_dma_pkg::axi_ar_t ar,
   input  logic                 arvalid,
   output logic                 arready,
   output eth_dma_pkg::axi_r_t  r,
   output logic                 rvalid,
   input  logic                 rready,
   input  logic                 ar_stall,   // hold arready low
   input  logic                 r_stall,    // delay the next beat
   output eth_dma_pkg::axi_ar_t ar_seen,    // last accepted request
   output int                   ar_count    // address transfers so far
);

   logic [7:0]  mem [0:4095];   // one 4 kB page, loaded by the testbench
   logic        busy;           // burst in progress
   logic [11:0] addr;           // next beat address
   logic [8:0]  beats_left;     // beats not yet issued

   // one burst at a time
   assign arready = !busy && !ar_stall;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy       <= 1'b0;
         addr       <= '0;
         beats_left <= '0;
         rvalid     <= 1'b0;
         r          <= '0;       // id and resp stay zero
         ar_seen    <= '0;
         ar_count   <= 0;
      end else begin
         if (arvalid && arready) begin
            busy       <= 1'b1;
            addr       <= {ar.addr[11:2], 2'b00};
            beats_left <= 9'(ar.len) + 9'd1;
            ar_seen    <= ar;
            ar_count   <= ar_count + 1;
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
            if (r.last) busy <= 1'b0;   // burst complete
         end
         // next beat once the slot is free, valid held until taken
         if (busy && beats_left != '0 && (!rvalid || rready) && !r_stall) begin
            rvalid     <= 1'b1;
            r.data     <= {mem[{addr[11:2], 2'd3}], mem[{addr[11:2], 2'd2}],
                           mem[{addr[11:2], 2'd1}], mem[addr]};   // little-endian
            r.last     <= (beats_left == 9'd1);
            addr       <= addr + 12'd4;
            beats_left <= beats_left - 9'd1;
         end
      end
   end

endmodule

//--- tb/tb_eth_dma_rd.sv
module tb_eth_dma_rd;

   localparam int CLK_HALF = 20;
   localparam int TIMEOUT  = 5000;   // cycles per transfer
   localparam int N_WORDS  = 255;    // words in a 1020 byte frame

   logic                 clk;
   logic                 arst_n;
   eth_dma_pkg::axi_ar_t ar;
   logic                 arvalid;
   logic                 arready;
   eth_dma_pkg::axi_r_t  r;
   logic                 rvalid;
   logic                 rready;
   logic [31:0]          dma_addr;
   logic [9:0]           dma_len;
   logic                 dma_run;
   logic                 dma_ready;
   logic [8:0]           buf_raddr;
   logic [31:0]          buf_rdata;
   logic                 ar_stall;
   logic                 r_stall;
   logic                 stall_on;    // stalls enabled for this run
   eth_dma_pkg::axi_ar_t ar_seen;
   int                   ar_count;
   logic [31:0]          rng;         // stimulus generator state
   logic [31:0]          stall_rng;   // stall generator state
   logic [7:0]           img [0:4095];              // copy of the slave memory
   logic [31:0]          exp_buf [0:N_WORDS-1];     // expected buffer contents
   int                   errors;
   int                   tests;
   int                   i;

   eth_dma_rd_top u_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .ar        (ar),
      .arvalid   (arvalid),
      .arready   (arready),
      .r         (r),
      .rvalid    (rvalid),
      .rready    (rready),
      .dma_addr  (dma_addr),
      .dma_len   (dma_len),
      .dma_run   (dma_run),
      .dma_ready (dma_ready),
      .buf_raddr (buf_raddr),
      .buf_rdata (buf_rdata)
   );

   axi_rd_mem_model u_mem (
      .clk      (clk),
      .arst_n   (arst_n),
      .ar       (ar),
      .arvalid  (arvalid),
      .arready  (arready),
      .r        (r),
      .rvalid   (rvalid),
      .rready   (rready),
      .ar_stall (ar_stall),
      .r_stall  (r_stall),
      .ar_seen  (ar_seen),
      .ar_count (ar_count)
   );

   always #(CLK_HALF) clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // random back-pressure on both channels
   always @(posedge clk) begin
      stall_rng = xorshift(stall_rng);
      ar_stall  <= stall_on && stall_rng[0];
      r_stall   <= stall_on && stall_rng[1];
   end

   // word k of a frame: bytes addr+4k.. little-endian, zero from len on
   function automatic logic [31:0] exp_word(input logic [31:0] addr, input int len,
                                            input int k);
      logic [31:0] w;
      int          b;
      w = '0;
      for (b = 0; b < 4; b++) begin
         if (4 * k + b < len) w[8*b +: 8] = img[12'(addr + 32'(4 * k + b))];
      end
      return w;
   endfunction

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic do_test(input string tag, input logic [31:0] addr, input int len,
                          input bit pulse);
      int t;
      int a;
      int err0;
      int ar0;
      int nbeats;
      err0   = errors;
      ar0    = ar_count;
      nbeats = (int'(addr[1:0]) + len + 3) / 4;
      @(posedge clk);
      dma_addr <= addr;
      dma_len  <= 10'(len);
      dma_run  <= 1'b1;
      @(posedge clk);
      dma_run <= 1'b0;
      @(negedge clk);
      compare("dma_ready", 32'(dma_ready), 32'd0);
      compare("arvalid", 32'(arvalid), 32'd1);   // request out right after run
      if (pulse) begin   // must be ignored while busy
         @(posedge clk);
         dma_run <= 1'b1;
         @(posedge clk);
         dma_run <= 1'b0;
      end
      t = 0;
      while (dma_ready !== 1'b1 && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (dma_ready !== 1'b1) begin
         $display("timeout: dma_ready stayed low for %0d cycles", TIMEOUT);
         errors++;
      end else begin
         for (a = 0; a < (len + 3) / 4; a++) exp_buf[8'(a)] = exp_word(addr, len, a);
         compare("ar.addr", ar_seen.addr, {addr[31:2], 2'b00});
         compare("ar.len", 32'(ar_seen.len), 32'(nbeats - 1));
         compare("ar.id", 32'(ar_seen.id), 32'd0);
         compare("ar.size", 32'(ar_seen.size), 32'd2);     // 4 bytes per beat
         compare("ar.burst", 32'(ar_seen.burst), 32'd1);   // incr
         compare("ar.cache", 32'(ar_seen.cache), 32'd2);
         compare("ar.prot", 32'(ar_seen.prot), 32'd2);
         compare("ar transfers", 32'(ar_count - ar0), 32'd1);
         // words past the frame keep what earlier runs left
         for (a = 0; a < N_WORDS; a++) begin
            @(posedge clk);
            buf_raddr <= 9'(a);
            @(posedge clk);
            @(negedge clk);
            compare($sformatf("buf_rdata[%0d]", a), buf_rdata, exp_buf[8'(a)]);
         end
      end
      tests++;
      $display("test %0d %s addr %h len %0d: %s", tests, tag, addr, len,
               (errors == err0) ? "ok" : "mismatch");
   endtask

   // address inside one page with the given offset
   task automatic run_frame(input string tag, input int len, input int off, input bit pulse);
      int room;
      int low;
      rng  = xorshift(rng);
      room = 4096 - len - off;
      low  = (int'(rng[15:0]) % (room / 4 + 1)) * 4 + off;
      rng  = xorshift(rng);
      do_test(tag, {rng[31:12], 12'(low)}, len, pulse);
   endtask

   task automatic random_frame(input string tag, input bit pulse);
      rng = xorshift(rng);
      run_frame(tag, int'(rng[15:0]) % 1020 + 1, int'(rng[17:16]), pulse);
   endtask

   initial begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      dma_addr  = '0;
      dma_len   = '0;
      dma_run   = 1'b0;
      buf_raddr = '0;
      ar_stall  = 1'b0;
      r_stall   = 1'b0;
      stall_on  = 1'b0;
      rng       = 32'd31;
      stall_rng = xorshift(32'd31);
      errors    = 0;
      tests     = 0;
      for (i = 0; i < 4096; i++) begin   // same bytes in slave and model
         rng              = xorshift(rng);
         img[12'(i)]      = rng[7:0];
         u_mem.mem[12'(i)] = rng[7:0];
      end
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      compare("dma_ready", 32'(dma_ready), 32'd1);
      compare("arvalid", 32'(arvalid), 32'd0);
      compare("rready", 32'(rready), 32'd0);
      tests++;
      $display("test %0d reset: %s", tests, (errors == 0) ? "ok" : "mismatch");
      run_frame("aligned", 1020, 0, 1'b0);   // full frame sets every checked word
      run_frame("aligned", 4, 0, 1'b0);
      run_frame("aligned", 64, 0, 1'b0);
      run_frame("aligned", 512, 0, 1'b0);
      for (i = 1; i < 4; i++) begin
         run_frame("offset", 128, i, 1'b0);
         run_frame("offset", 1020, i, 1'b0);
      end
      for (i = 1; i < 8; i++) run_frame("ragged", i, i % 4, 1'b0);
      run_frame("ragged", 1019, 2, 1'b0);
      run_frame("ragged", 301, 3, 1'b0);
      stall_on <= 1'b1;
      repeat (6) random_frame("stall", 1'b0);
      repeat (4) random_frame("pulse", 1'b1);
      repeat (20) begin   // stalls on or off per run
         rng = xorshift(rng);
         stall_on <= rng[20];
         random_frame("random", rng[21]);
      end
      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- build.f
hdl/eth_dma_pkg.sv
hdl/eth_burst_align.sv
hdl/eth_dma_rd.sv
hdl/eth_frame_buf.sv
hdl/eth_dma_rd_top.sv
tb/axi_rd_mem_model.sv
tb/tb_eth_dma_rd.sv

//--- Makefile
# any of these can be set on the command line
VERILATOR ?= verilator
TOP       ?= tb_eth_dma_rd
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
